//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      ?= tb_uxn_host
FILELIST ?= list.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/mem_port_model.sv
/*
  Behavioral DRAM behind each user port, 256 words per port.
  Unwritten words read zero; cmd_full and rd_overflow are injected
  by the testbench, wr_full never rises.
  A command given while cmd_full is high is dropped.
*/
`default_nettype none

module mem_port_model (
   input  logic                 ifclk,
   input  logic                 rst,
   input  mcb_pkg::mcb_req_t    mcb_req [mcb_pkg::NUM_PORTS],
   output mcb_pkg::mcb_rsp_t    mcb_rsp [mcb_pkg::NUM_PORTS],
   input  mcb_pkg::port_flags_t cmd_full_inj,
   input  mcb_pkg::port_flags_t overflow_inj
);
   timeunit 1ns;
   timeprecision 100ps;

   for (genvar p = 0; p < mcb_pkg::NUM_PORTS; p++) begin : g_mem
      logic [31:0] mem [256];
      logic [31:0] wq [$];
      logic [31:0] rq [$];
      logic        rd_empty_q;
      logic [31:0] rd_data_q;
      logic        underrun_q;

      always @(posedge ifclk) begin
         if (rst) begin
            for (int a = 0; a < 256; a++) begin
               mem[a] = '0;
            end
            wq.delete();
            rq.delete();
            rd_empty_q <= 1'b1;
            rd_data_q  <= '0;
            underrun_q <= 1'b0;
         end else begin
            underrun_q <= 1'b0;
            if (mcb_req[p].rd_en && rq.size() > 0) begin
               void'(rq.pop_front());
            end
            if (mcb_req[p].wr_en) begin
               wq.push_back(mcb_req[p].wr_data);
            end
            if (mcb_req[p].cmd_en && !cmd_full_inj[p] &&
                mcb_req[p].cmd_instr == mcb_pkg::MCB_WRITE) begin
               // Write command with nothing queued is an underrun
               if (wq.size() > 0) begin
                  mem[mcb_req[p].cmd_byte_addr[9:2]] = wq.pop_front();
               end else begin
                  underrun_q <= 1'b1;
               end
            end else if (mcb_req[p].cmd_en && !cmd_full_inj[p]) begin
               rq.push_back(mem[mcb_req[p].cmd_byte_addr[9:2]]);
            end
            rd_empty_q <= (rq.size() == 0);
            rd_data_q  <= (rq.size() > 0) ? rq[0] : '0;
         end
      end

      assign mcb_rsp[p] = '{cmd_full: cmd_full_inj[p], wr_full: 1'b0, rd_empty: rd_empty_q,
                            rd_data: rd_data_q, wr_underrun: underrun_q,
                            rd_overflow: overflow_inj[p]};
   end

endmodule

`default_nettype wire

//--- bench/tb_uxn_host.sv
/*
  Testbench for uxn_host_top with a memory model behind the four ports.
  Host inputs change on the falling edge; reads go to a compare process
  that checks them against a shadow memory. Word addresses stay below 256.
*/
`default_nettype none

module tb_uxn_host;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT = 200;

   typedef struct packed {
      host_pkg::term_addr_t term;
      host_pkg::reg_addr_t  addr;
      host_pkg::reg_data_t  data;
   } sample_t;

   logic                 ifclk;
   logic                 rst;
   logic                 calib_done;
   host_pkg::host_req_t  host_req;
   host_pkg::host_rsp_t  host_rsp;
   mcb_pkg::mcb_req_t    mcb_req [mcb_pkg::NUM_PORTS];
   mcb_pkg::mcb_rsp_t    mcb_rsp [mcb_pkg::NUM_PORTS];
   mcb_pkg::port_flags_t cmd_full_inj;
   mcb_pkg::port_flags_t overflow_inj;

   logic [31:0] shadow [mcb_pkg::NUM_PORTS][256];
   logic [31:0] exp_calib;
   logic [31:0] exp_errors;
   sample_t     pending [$];
   int          checks;
   int          errors;
   bit          timed_out;

   uxn_host_top dut0 (
      .ifclk      (ifclk),
      .rst        (rst),
      .host_req   (host_req),
      .host_rsp   (host_rsp),
      .calib_done (calib_done),
      .mcb_req    (mcb_req),
      .mcb_rsp    (mcb_rsp)
   );

   mem_port_model mem0 (
      .ifclk        (ifclk),
      .rst          (rst),
      .mcb_req      (mcb_req),
      .mcb_rsp      (mcb_rsp),
      .cmd_full_inj (cmd_full_inj),
      .overflow_inj (overflow_inj)
   );

   initial begin
      ifclk = 1'b0;
      forever begin
         #20 ifclk = ~ifclk;
      end
   end

   function automatic host_pkg::term_addr_t port_term(input int p);
      return host_pkg::term_addr_t'(int'(host_pkg::TERM_DRAM_BASE) + p);
   endfunction

   // Expected read data from the terminal map and the shadow memory
   function automatic host_pkg::reg_data_t ref_read(input host_pkg::term_addr_t term,
                                                    input host_pkg::reg_addr_t addr);
      int off;
      off = int'(term) - int'(host_pkg::TERM_DRAM_BASE);
      if (off >= 0 && off < mcb_pkg::NUM_PORTS) begin
         return shadow[off][addr[7:0]];
      end
      if (term == host_pkg::TERM_DUMMY_FPGA) begin
         return 32'hBBAA9988;
      end
      if (term == host_pkg::TERM_DRAM_CTRL && addr == 32'd0) begin
         return exp_calib;
      end
      if (term == host_pkg::TERM_DRAM_CTRL && addr == 32'd1) begin
         return exp_errors;
      end
      return '0;
   endfunction

   task automatic wait_ready(input bit for_read, input string what);
      int   n;
      logic rdy;
      n = 0;
      @(negedge ifclk);
      rdy = for_read ? host_rsp.read_rdy : host_rsp.write_rdy;
      while (rdy !== 1'b1 && n < WAIT_LIMIT) begin
         @(negedge ifclk);
         n++;
         rdy = for_read ? host_rsp.read_rdy : host_rsp.write_rdy;
      end
      if (rdy !== 1'b1) begin
         $display("Timeout at %0t: %s never went high", $time, what);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic check_count(input int len);
      @(negedge ifclk);
      checks++;
      if (host_rsp.transfer_status !== host_pkg::xfer_status_t'(len)) begin
         errors++;
         $display("Mismatch at %0t: transfer_status %0d, expected %0d", $time,
                  host_rsp.transfer_status, len);
      end
   endtask

   task automatic write_burst(input int p, input host_pkg::reg_addr_t addr, input int len);
      host_pkg::reg_data_t d;
      host_pkg::reg_addr_t wa;
      @(negedge ifclk);
      host_req.term_addr  = port_term(p);
      host_req.reg_addr   = addr;
      host_req.write_mode = 1'b1;
      for (int k = 0; k < len; k++) begin
         wait_ready(1'b0, "write_rdy");
         d  = $urandom;
         wa = addr + host_pkg::reg_addr_t'(k);
         host_req.reg_datai = d;
         host_req.write     = 1'b1;
         shadow[p][wa[7:0]] = d;
         @(negedge ifclk);
         host_req.write = 1'b0;
      end
      check_count(len);
      host_req.write_mode = 1'b0;
   endtask

   task automatic read_burst(input host_pkg::term_addr_t term, input host_pkg::reg_addr_t addr,
                             input int len, input bit count_words);
      sample_t s;
      @(negedge ifclk);
      host_req.term_addr = term;
      host_req.reg_addr  = addr;
      host_req.read_mode = 1'b1;
      for (int k = 0; k < len; k++) begin
         wait_ready(1'b1, "read_rdy");
         s.term = term;
         s.addr = addr + host_pkg::reg_addr_t'(k);
         s.data = host_rsp.reg_datao;
         pending.push_back(s);
         host_req.read = 1'b1;
         @(negedge ifclk);
         host_req.read = 1'b0;
      end
      if (count_words) begin
         check_count(len);
      end
      host_req.read_mode = 1'b0;
   endtask

   task automatic end_test(input int num, input string name);
      int n;
      n = 0;
      while (pending.size() != 0 && n < 10) begin
         @(negedge ifclk);
         n++;
      end
      if (pending.size() != 0) begin
         $display("Timeout at %0t: read results were never compared", $time);
         errors++;
         timed_out = 1'b1;
      end
      $display("Test %0d (%s) finished, %0d errors so far", num, name, errors);
   endtask

   always @(negedge ifclk) begin : compare
      sample_t             s;
      host_pkg::reg_data_t want;
      while (pending.size() != 0) begin
         s    = pending.pop_front();
         want = ref_read(s.term, s.addr);
         checks++;
         if (s.data !== want) begin
            errors++;
            $display("Mismatch at %0t: term %h addr %0d read %h, expected %h", $time,
                     s.term, s.addr, s.data, want);
         end
      end
   end

   // Every command on a port carries a single word
   always @(posedge ifclk) begin : burst_check
      for (int p = 0; p < mcb_pkg::NUM_PORTS; p++) begin
         if (!rst && mcb_req[p].cmd_en && mcb_req[p].cmd_bl !== '0) begin
            errors++;
            $display("Mismatch at %0t: port %0d command with cmd_bl %0d", $time, p,
                     mcb_req[p].cmd_bl);
         end
      end
   end

   initial begin
      wait (timed_out);
      $display("Simulation failed");
      $finish;
   end

   initial begin : stimulus
      int                  len;
      host_pkg::reg_addr_t addr;
      host_pkg::reg_data_t d;
      host_pkg::reg_addr_t b_addr [12];
      int                  b_len [12];
      void'($urandom(16643));
      rst          = 1'b1;
      calib_done   = 1'b0;
      host_req     = '0;
      cmd_full_inj = '0;
      overflow_inj = '0;
      exp_calib    = '0;
      exp_errors   = '0;
      checks       = 0;
      errors       = 0;
      timed_out    = 1'b0;
      for (int p = 0; p < mcb_pkg::NUM_PORTS; p++) begin
         for (int a = 0; a < 256; a++) begin
            shadow[p][a] = '0;
         end
      end
      repeat (10) @(negedge ifclk);
      rst = 1'b0;

      read_burst(host_pkg::TERM_DUMMY_FPGA, 32'd0, 1, 1'b0);
      read_burst(16'h0055, 32'd3, 1, 1'b0);
      @(negedge ifclk);
      host_req.term_addr = 16'h0055;
      host_req.read_mode = 1'b1;
      @(negedge ifclk);
      checks++;
      if (host_rsp.read_rdy !== 1'b1) begin
         errors++;
         $display("Mismatch at %0t: read_rdy low on an unknown terminal", $time);
      end
      host_req.read_mode = 1'b0;
      end_test(1, "fixed terminals");

      // Three bursts per port, all written before any read
      for (int p = 0; p < mcb_pkg::NUM_PORTS; p++) begin
         for (int b = 0; b < 3; b++) begin
            len  = 1 + int'($urandom % 8);
            addr = host_pkg::reg_addr_t'($urandom % 248);
            b_addr[p * 3 + b] = addr;
            b_len[p * 3 + b]  = len;
            write_burst(p, addr, len);
         end
      end
      for (int p = 0; p < mcb_pkg::NUM_PORTS; p++) begin
         for (int b = 0; b < 3; b++) begin
            read_burst(port_term(p), b_addr[p * 3 + b], b_len[p * 3 + b], 1'b1);
         end
      end
      end_test(2, "random bursts on all ports");

      write_burst(1, 32'd200, 5);
      read_burst(port_term(1), 32'd200, 5, 1'b1);
      end_test(3, "word count");

      @(negedge ifclk);
      calib_done      = 1'b1;
      overflow_inj[2] = 1'b1;
      @(negedge ifclk);
      overflow_inj[2] = 1'b0;
      exp_calib       = 32'd1;
      exp_errors      = 32'h0000_0040;
      read_burst(host_pkg::TERM_DRAM_CTRL, 32'd0, 1, 1'b0);
      read_burst(host_pkg::TERM_DRAM_CTRL, 32'd1, 1, 1'b0);
      end_test(4, "status terminal");

      @(negedge ifclk);
      host_req.term_addr  = port_term(3);
      host_req.reg_addr   = 32'd50;
      host_req.write_mode = 1'b1;
      wait_ready(1'b0, "write_rdy on port 3");
      d = $urandom;
      host_req.reg_datai = d;
      host_req.write     = 1'b1;
      shadow[3][50]      = d;
      @(negedge ifclk);
      host_req.write  = 1'b0;
      cmd_full_inj[3] = 1'b1;
      // Write command stays parked while the port is full
      repeat (20) begin
         @(negedge ifclk);
         checks++;
         if (host_rsp.write_rdy !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: write_rdy high while cmd_full is held", $time);
         end
      end
      cmd_full_inj[3] = 1'b0;
      check_count(1);
      host_req.write_mode = 1'b0;
      read_burst(port_term(3), 32'd50, 1, 1'b1);
      end_test(5, "held write command");

      write_burst(0, 32'd10, 6);
      write_burst(0, 32'd80, 4);
      read_burst(port_term(0), 32'd10, 5, 1'b1);
      read_burst(port_term(0), 32'd80, 4, 1'b1);
      end_test(6, "read transfer ended early");

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
verilog/host_pkg.sv
verilog/mcb_pkg.sv
verilog/term_decode.sv
verilog/dram_port_bridge.sv
verilog/term_readback.sv
verilog/uxn_host_top.sv
bench/mem_port_model.sv
bench/tb_uxn_host.sv

//--- verilog/dram_port_bridge.sv
/*
  Host word transfers to one DRAM user port, one word per command.
  Expects strobes already qualified for this port's terminal.
  Reads prefetch one word; a word left over when read_mode falls
  is drained from the port and dropped.
*/
`default_nettype none

module dram_port_bridge (
   input  logic                ifclk,
   input  logic                rst,
   input  host_pkg::host_req_t host_req,
   output host_pkg::host_rsp_t host_rsp,
   output mcb_pkg::mcb_req_t   mcb_req,
   input  mcb_pkg::mcb_rsp_t   mcb_rsp
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WRITE_DATA,
      ST_WRITE_CMD,
      ST_READ_WAIT,
      ST_HOLD
   } state_t;

   state_t                 state;
   host_pkg::xfer_status_t word_idx;
   host_pkg::xfer_status_t xfer_cnt;
   host_pkg::reg_data_t    data_q;
   mcb_pkg::byte_addr_t    wr_addr;
   logic                   discard;

   host_pkg::reg_addr_t    word_addr;
   mcb_pkg::byte_addr_t    cur_addr;
   logic                   write_rdy;
   logic                   wr_accept;
   logic                   issue_wr;
   logic                   issue_rd;
   logic                   drain;
   logic                   rd_taken;

   // Word k of a transfer lives at reg_addr + k
   assign word_addr = host_req.reg_addr + host_pkg::reg_addr_t'(word_idx);
   assign cur_addr  = mcb_pkg::byte_addr_t'({word_addr, 2'b00});

   assign write_rdy = (state == ST_IDLE) && !mcb_rsp.cmd_full && !mcb_rsp.wr_full;
   assign wr_accept = host_req.write && write_rdy;
   assign issue_wr  = (state == ST_WRITE_CMD) && !mcb_rsp.cmd_full;
   assign issue_rd  = (state == ST_IDLE) && host_req.read_mode && !host_req.write_mode &&
                      !mcb_rsp.cmd_full;
   assign drain     = (state == ST_READ_WAIT) && !mcb_rsp.rd_empty;
   assign rd_taken  = (state == ST_HOLD) && host_req.read;

   always_ff @(posedge ifclk) begin
      if (rst) begin
         state    <= ST_IDLE;
         discard  <= 1'b0;
         word_idx <= '0;
         xfer_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (wr_accept) begin
                  state <= ST_WRITE_DATA;
               end else if (issue_rd) begin
                  state <= ST_READ_WAIT;
               end
            end
            ST_WRITE_DATA: begin
               if (!mcb_rsp.wr_full) begin
                  state <= ST_WRITE_CMD;
               end
            end
            ST_WRITE_CMD: begin
               if (issue_wr) begin
                  state <= ST_IDLE;
               end
            end
            ST_READ_WAIT: begin
               if (drain) begin
                  if (discard || !host_req.read_mode) begin
                     state <= ST_IDLE;
                  end else begin
                     state <= ST_HOLD;
                  end
               end
            end
            ST_HOLD: begin
               if (rd_taken || !host_req.read_mode) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase

         // Outstanding word belongs to a transfer that has already ended
         if (drain) begin
            discard <= 1'b0;
         end else if (state == ST_READ_WAIT && !host_req.read_mode) begin
            discard <= 1'b1;
         end

         if (!host_req.read_mode && !host_req.write_mode) begin
            word_idx <= '0;
            xfer_cnt <= '0;
         end else begin
            if (wr_accept || issue_rd) begin
               word_idx <= word_idx + 1'b1;
            end
            if (wr_accept || rd_taken) begin
               xfer_cnt <= xfer_cnt + 1'b1;
            end
         end
      end
   end

   // Shared word register, write data on the way out or read data on the way in
   always_ff @(posedge ifclk) begin
      if (wr_accept) begin
         data_q  <= host_req.reg_datai;
         wr_addr <= cur_addr;
      end else if (drain) begin
         data_q <= mcb_rsp.rd_data;
      end
   end

   always_comb begin
      mcb_req.cmd_en = issue_wr || issue_rd;
      if (state == ST_WRITE_CMD) begin
         mcb_req.cmd_instr     = mcb_pkg::MCB_WRITE;
         mcb_req.cmd_byte_addr = wr_addr;
      end else begin
         mcb_req.cmd_instr     = mcb_pkg::MCB_READ;
         mcb_req.cmd_byte_addr = cur_addr;
      end
      mcb_req.cmd_bl  = '0;
      mcb_req.wr_en   = (state == ST_WRITE_DATA) && !mcb_rsp.wr_full;
      mcb_req.wr_data = data_q;
      mcb_req.rd_en   = drain;

      host_rsp.reg_datao       = data_q;
      host_rsp.read_rdy        = (state == ST_HOLD);
      host_rsp.write_rdy       = write_rdy;
      host_rsp.transfer_status = xfer_cnt;
   end

   // Queued write data is followed by its command unless the port is full
   assert property (@(posedge ifclk) disable iff (rst)
                    mcb_req.wr_en |=>
                       (mcb_req.cmd_en && mcb_req.cmd_instr == mcb_pkg::MCB_WRITE) ||
                       mcb_rsp.cmd_full)
      else $error("dram_port_bridge: write data without a write command");

   // The host only sees a word that was popped from the read queue
   assert property (@(posedge ifclk) disable iff (rst)
                    $rose(host_rsp.read_rdy) |-> $past(mcb_req.rd_en))
      else $error("dram_port_bridge: read_rdy without a popped word");

endmodule

`default_nettype wire

//--- verilog/host_pkg.sv
/*
  Types and constants of the host register bus (di bus) on ifclk.
  Register addresses count 32-bit words, not bytes.
  Terminal numbers must match the host software's terminal map.
*/
`default_nettype none

package host_pkg;

   typedef logic [15:0] term_addr_t;
   typedef logic [31:0] reg_addr_t;
   typedef logic [31:0] reg_data_t;
   typedef logic [15:0] xfer_status_t;

   // Host to FPGA, levels held for the whole transfer except the strobes
   typedef struct packed {
      term_addr_t term_addr;
      reg_addr_t  reg_addr;
      reg_data_t  reg_datai;
      logic       read_mode;
      logic       read;
      logic       write_mode;
      logic       write;
   } host_req_t;

   typedef struct packed {
      reg_data_t    reg_datao;
      logic         read_rdy;
      logic         write_rdy;
      xfer_status_t transfer_status;
   } host_rsp_t;

   // DRAM port i answers at TERM_DRAM_BASE + i
   localparam term_addr_t TERM_DRAM_BASE  = 16'h0010;
   localparam term_addr_t TERM_DRAM_CTRL  = 16'h0020;
   localparam term_addr_t TERM_DUMMY_FPGA = 16'h0030;

   localparam reg_data_t DUMMY_WORD = 32'hBBAA9988;

   // Status registers of TERM_DRAM_CTRL
   localparam reg_addr_t CTRL_REG_CALIB  = 32'd0;
   localparam reg_addr_t CTRL_REG_ERRORS = 32'd1;

endpackage

`default_nettype wire

//--- verilog/mcb_pkg.sv
/*
  Types of the DRAM memory-controller user ports.
  Only single-word commands are used, so cmd_bl is always zero.
  Data ports are 32 bits wide with no write mask.
*/
`default_nettype none

package mcb_pkg;

   localparam int NUM_PORTS = 4;

   typedef logic [29:0] byte_addr_t;
   typedef logic [5:0]  burst_len_t;
   typedef logic [31:0] mcb_data_t;
   typedef logic [NUM_PORTS-1:0] port_flags_t;

   typedef enum logic [2:0] {
      MCB_WRITE = 3'b000,
      MCB_READ  = 3'b001
   } mcb_instr_t;

   // Driven by a bridge toward the controller
   typedef struct packed {
      logic       cmd_en;
      mcb_instr_t cmd_instr;
      burst_len_t cmd_bl;
      byte_addr_t cmd_byte_addr;
      logic       wr_en;
      mcb_data_t  wr_data;
      logic       rd_en;
   } mcb_req_t;

   // Returned by the controller, rd_data is valid while rd_empty is low
   typedef struct packed {
      logic      cmd_full;
      logic      wr_full;
      logic      rd_empty;
      mcb_data_t rd_data;
      logic      wr_underrun;
      logic      rd_overflow;
   } mcb_rsp_t;

endpackage

`default_nettype wire

//--- verilog/term_decode.sv
/*
  Steers the host bus to the DRAM port bridges.
  Purely combinational; address and data pass through unchanged,
  only the strobes and mode levels are qualified per port.
*/
`default_nettype none

module term_decode (
   input  host_pkg::host_req_t  host_req,
   output mcb_pkg::port_flags_t port_sel,
   output host_pkg::host_req_t  port_req [mcb_pkg::NUM_PORTS]
);

   always_comb begin
      for (int i = 0; i < mcb_pkg::NUM_PORTS; i++) begin
         port_sel[i] = host_req.term_addr ==
                       host_pkg::term_addr_t'(host_pkg::TERM_DRAM_BASE + i);

         port_req[i]            = host_req;
         port_req[i].read       = host_req.read & port_sel[i];
         port_req[i].read_mode  = host_req.read_mode & port_sel[i];
         port_req[i].write      = host_req.write & port_sel[i];
         port_req[i].write_mode = host_req.write_mode & port_sel[i];
      end
   end

endmodule

`default_nettype wire

//--- verilog/term_readback.sv
/*
  Identification and DRAM status terminals plus the host response mux.
  Error flags are sticky until reset; calibration is one cycle late.
  Unknown terminals read zero and are always ready.
*/
`default_nettype none

module term_readback (
   input  logic                 ifclk,
   input  logic                 rst,
   input  host_pkg::host_req_t  host_req,
   input  mcb_pkg::port_flags_t port_sel,
   input  host_pkg::host_rsp_t  port_rsp [mcb_pkg::NUM_PORTS],
   input  mcb_pkg::mcb_rsp_t    mcb_rsp [mcb_pkg::NUM_PORTS],
   input  logic                 calib_done,
   output host_pkg::host_rsp_t  host_rsp
);

   logic                 calib_q;
   mcb_pkg::port_flags_t underrun_q;
   mcb_pkg::port_flags_t overflow_q;
   mcb_pkg::port_flags_t underrun_now;
   mcb_pkg::port_flags_t overflow_now;
   host_pkg::reg_data_t  ctrl_data;

   always_comb begin
      for (int i = 0; i < mcb_pkg::NUM_PORTS; i++) begin
         underrun_now[i] = mcb_rsp[i].wr_underrun;
         overflow_now[i] = mcb_rsp[i].rd_overflow;
      end
   end

   always_ff @(posedge ifclk) begin
      if (rst) begin
         calib_q    <= 1'b0;
         underrun_q <= '0;
         overflow_q <= '0;
      end else begin
         calib_q    <= calib_done;
         underrun_q <= underrun_q | underrun_now;
         overflow_q <= overflow_q | overflow_now;
      end
   end

   // Underrun in the low nibble, overflow above it
   always_comb begin
      case (host_req.reg_addr)
         host_pkg::CTRL_REG_CALIB:  ctrl_data = host_pkg::reg_data_t'(calib_q);
         host_pkg::CTRL_REG_ERRORS: ctrl_data = host_pkg::reg_data_t'({overflow_q, underrun_q});
         default:                   ctrl_data = '0;
      endcase
   end

   always_comb begin
      host_rsp.reg_datao       = '0;
      host_rsp.read_rdy        = 1'b1;
      host_rsp.write_rdy       = 1'b1;
      host_rsp.transfer_status = '0;

      if (host_req.term_addr == host_pkg::TERM_DUMMY_FPGA) begin
         host_rsp.reg_datao = host_pkg::DUMMY_WORD;
      end else if (host_req.term_addr == host_pkg::TERM_DRAM_CTRL) begin
         host_rsp.reg_datao = ctrl_data;
      end

      // At most one select is high
      for (int i = 0; i < mcb_pkg::NUM_PORTS; i++) begin
         if (port_sel[i]) begin
            host_rsp = port_rsp[i];
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/uxn_host_top.sv
/*
  Host register side of the board top level.
  Memory-controller user ports are brought out as top-level ports;
  calib_done comes from the controller and is sampled on ifclk.
*/
`default_nettype none

module uxn_host_top (
   input  logic                ifclk,
   input  logic                rst,
   input  host_pkg::host_req_t host_req,
   output host_pkg::host_rsp_t host_rsp,
   input  logic                calib_done,
   output mcb_pkg::mcb_req_t   mcb_req [mcb_pkg::NUM_PORTS],
   input  mcb_pkg::mcb_rsp_t   mcb_rsp [mcb_pkg::NUM_PORTS]
);

   mcb_pkg::port_flags_t port_sel;
   host_pkg::host_req_t  port_req [mcb_pkg::NUM_PORTS];
   host_pkg::host_rsp_t  port_rsp [mcb_pkg::NUM_PORTS];

   term_decode decode0 (
      .host_req (host_req),
      .port_sel (port_sel),
      .port_req (port_req)
   );

   // One bridge per DRAM user port
   for (genvar i = 0; i < mcb_pkg::NUM_PORTS; i++) begin : g_port
      dram_port_bridge bridge0 (
         .ifclk    (ifclk),
         .rst      (rst),
         .host_req (port_req[i]),
         .host_rsp (port_rsp[i]),
         .mcb_req  (mcb_req[i]),
         .mcb_rsp  (mcb_rsp[i])
      );
   end

   term_readback readback0 (
      .ifclk      (ifclk),
      .rst        (rst),
      .host_req   (host_req),
      .port_sel   (port_sel),
      .port_rsp   (port_rsp),
      .mcb_rsp    (mcb_rsp),
      .calib_done (calib_done),
      .host_rsp   (host_rsp)
   );

endmodule

`default_nettype wire
